//--- fe_cfg.svh
// sizing of the fetch front end
// block size, history length, predictor and BTB geometry,
// return stack depth, reset pointer and predictor throttle periods
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

`define FE_ADDR_W 32

// log2 of the 32-byte fetch block
`define FE_BLOCK_BITS 5

`define FE_GHT_W 8

// 256 entries in each direction table
`define FE_PRED_IDX_W 8

// 64 BTB sets, tag is the block number above the set index
`define FE_BTB_SETS_W 6
`define FE_BTB_TAG_W (`FE_ADDR_W - `FE_BLOCK_BITS - `FE_BTB_SETS_W)

// 16-entry return stack
`define FE_RAS_DEPTH_W 4

`define FE_RESET_IP 32'h0000_1000

// mispredicts between toggles of tables B and C
`define FE_THROTTLE_B 4
`define FE_THROTTLE_C 16

`endif

//--- fe_fetch_pkg.sv
// fetch path types
// fetch address, global history and branch slot number
`default_nettype none

`include "fe_cfg.svh"

package fe_fetch_pkg;

  // byte address of a fetch block
  typedef logic [`FE_ADDR_W-1:0] addr_t;

  // newest outcome in bit 0
  typedef logic [`FE_GHT_W-1:0] ght_t;

  // two branch slots per block
  typedef logic slot_t;

endpackage

`default_nettype wire

//--- fe_btb_pkg.sv
// branch target buffer and predictor types
// branch kind encoding, BTB slot entry, direction predictor entry
`default_nettype none

`include "fe_cfg.svh"

package fe_btb_pkg;

  typedef enum logic [1:0] {
    br_cond = 2'd0,
    br_jump = 2'd1,
    br_call = 2'd2,
    br_ret  = 2'd3
  } br_kind_t;

  // one BTB slot
  typedef struct packed {
    logic                     valid;
    logic [`FE_BTB_TAG_W-1:0] tag;    // block number above the set index
    fe_fetch_pkg::addr_t      target;
    br_kind_t                 kind;
  } btb_entry_t;

  // one toggle bit per slot, bit s belongs to slot s
  typedef logic [1:0] pred_entry_t;

endpackage

`default_nettype wire

//--- fe_table.sv
// generic table memory
// combinational read port, synchronous write port, cleared on reset
`default_nettype none

`include "fe_cfg.svh"

module fe_table #(
  parameter type entry_t = logic [1:0],
  parameter int  DEPTH   = 1 << `FE_PRED_IDX_W,
  localparam int IDX_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [IDX_W-1:0] rd_idx,
  output entry_t           rd_data,
  input  logic             wr_en,
  input  logic [IDX_W-1:0] wr_idx,
  input  entry_t           wr_data
);

  entry_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // same-cycle write is seen by the read from the next cycle on
  assign rd_data = mem[rd_idx];

  a_wr_idx_range: assert property (
    @(posedge clk) disable iff (rst)
    wr_en |-> wr_idx < DEPTH
  );

endmodule

`default_nettype wire

//--- fe_direction.sv
// direction predictor
// three hashed toggle tables, XOR-combined per slot
// mispredict repair: table A every time, B and C throttled by counters
`default_nettype none

`include "fe_cfg.svh"

module fe_direction (
  input  logic                 clk,
  input  logic                 rst,
  input  fe_fetch_pkg::addr_t  fetch_ip,
  input  fe_fetch_pkg::ght_t   ght,
  output logic [1:0]           dir_taken,
  input  logic                 ret_valid,
  input  logic                 ret_mispred,
  input  fe_btb_pkg::br_kind_t ret_kind,
  input  fe_fetch_pkg::slot_t  ret_slot,
  input  fe_fetch_pkg::addr_t  ret_src_ip,
  input  fe_fetch_pkg::ght_t   ret_ght
);
  import fe_fetch_pkg::*;
  import fe_btb_pkg::*;

  localparam int IDX_W = `FE_PRED_IDX_W;
  localparam int CNT_B_W = $clog2(`FE_THROTTLE_B);
  localparam int CNT_C_W = $clog2(`FE_THROTTLE_C);
  localparam logic [CNT_B_W-1:0] LAST_B = CNT_B_W'(`FE_THROTTLE_B - 1);
  localparam logic [CNT_C_W-1:0] LAST_C = CNT_C_W'(`FE_THROTTLE_C - 1);
  // history bits in the index of tables A, B, C
  localparam int HIST_BITS [3] = '{2, 4, 6};

  logic             cond_mispred;
  logic [2:0]       tog;
  logic [CNT_B_W-1:0] cnt_b;
  logic [CNT_C_W-1:0] cnt_c;
  logic [IDX_W-1:0] rd_idx [3];
  logic [IDX_W-1:0] ret_idx [3];
  pred_entry_t      ent [3];
  pred_entry_t      slot_mask;

  // block-number bits on top, low history bits below
  function automatic logic [IDX_W-1:0] pred_hash(
    input addr_t ip,
    input ght_t  h,
    input int    hist_bits
  );
    logic [IDX_W-1:0] blk;
    logic [IDX_W-1:0] mask;
    blk  = ip[`FE_BLOCK_BITS +: IDX_W];
    mask = {IDX_W{1'b1}} >> (IDX_W - hist_bits);
    return (blk << hist_bits) | (h & mask);
  endfunction

  assign cond_mispred = ret_valid && ret_mispred && ret_kind == br_cond;
  assign tog = {cond_mispred && cnt_c == LAST_C, cond_mispred && cnt_b == LAST_B, cond_mispred};

  always_comb begin
    slot_mask = '0;
    slot_mask[ret_slot] = 1'b1;
    for (int t = 0; t < 3; t++) begin
      ret_idx[t] = pred_hash(ret_src_ip, ret_ght, HIST_BITS[t]);
      // the redirect squashes this block, so the read port serves the toggle
      rd_idx[t] = cond_mispred ? ret_idx[t] : pred_hash(fetch_ip, ght, HIST_BITS[t]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_b <= '0;
      cnt_c <= '0;
    end else if (cond_mispred) begin
      cnt_b <= (cnt_b == LAST_B) ? '0 : cnt_b + 1'b1;
      cnt_c <= (cnt_c == LAST_C) ? '0 : cnt_c + 1'b1;
    end
  end

  fe_table #(.entry_t(pred_entry_t), .DEPTH(1 << IDX_W)) tbl_a (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx[0]),
    .rd_data (ent[0]),
    .wr_en   (tog[0]),
    .wr_idx  (ret_idx[0]),
    .wr_data (ent[0] ^ slot_mask)
  );

  fe_table #(.entry_t(pred_entry_t), .DEPTH(1 << IDX_W)) tbl_b (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx[1]),
    .rd_data (ent[1]),
    .wr_en   (tog[1]),
    .wr_idx  (ret_idx[1]),
    .wr_data (ent[1] ^ slot_mask)
  );

  fe_table #(.entry_t(pred_entry_t), .DEPTH(1 << IDX_W)) tbl_c (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (rd_idx[2]),
    .rd_data (ent[2]),
    .wr_en   (tog[2]),
    .wr_idx  (ret_idx[2]),
    .wr_data (ent[2] ^ slot_mask)
  );

  assign dir_taken = ent[0] ^ ent[1] ^ ent[2];

endmodule

`default_nettype wire

//--- fe_btb.sv
// branch target buffer
// two tagged slots per set, looked up by fetch block
// retiring branches install their slot
`default_nettype none

`include "fe_cfg.svh"

module fe_btb (
  input  logic                         clk,
  input  logic                         rst,
  input  fe_fetch_pkg::addr_t          fetch_ip,
  output logic [1:0]                   slot_hit,
  output fe_btb_pkg::btb_entry_t [1:0] slot_entry,
  input  logic                         ret_valid,
  input  fe_fetch_pkg::slot_t          ret_slot,
  input  fe_fetch_pkg::addr_t          ret_src_ip,
  input  fe_btb_pkg::br_kind_t         ret_kind,
  input  fe_fetch_pkg::addr_t          ret_target
);
  import fe_fetch_pkg::*;
  import fe_btb_pkg::*;

  localparam int SET_W = `FE_BTB_SETS_W;
  localparam int TAG_W = `FE_BTB_TAG_W;
  localparam int TAG_LSB = `FE_BLOCK_BITS + SET_W;

  logic [SET_W-1:0] fetch_set;
  logic [SET_W-1:0] ret_set;
  logic [TAG_W-1:0] fetch_tag;
  btb_entry_t       new_entry;

  assign fetch_set = fetch_ip[`FE_BLOCK_BITS +: SET_W];
  assign fetch_tag = fetch_ip[TAG_LSB +: TAG_W];
  assign ret_set   = ret_src_ip[`FE_BLOCK_BITS +: SET_W];

  always_comb begin
    new_entry.valid  = 1'b1;
    new_entry.tag    = ret_src_ip[TAG_LSB +: TAG_W];
    new_entry.target = ret_target;
    new_entry.kind   = ret_kind;
  end

  for (genvar s = 0; s < 2; s++) begin : g_slot
    fe_table #(.entry_t(btb_entry_t), .DEPTH(1 << SET_W)) u_way (
      .clk     (clk),
      .rst     (rst),
      .rd_idx  (fetch_set),
      .rd_data (slot_entry[s]),
      .wr_en   (ret_valid && ret_slot == slot_t'(s)),
      .wr_idx  (ret_set),
      .wr_data (new_entry)
    );

    assign slot_hit[s] = slot_entry[s].valid && slot_entry[s].tag == fetch_tag;
  end

endmodule

`default_nettype wire

//--- fe_ras.sv
// return address stack
// circular, wrapping pointer, push on call hits, pop on return hits
`default_nettype none

`include "fe_cfg.svh"

module fe_ras (
  input  logic                clk,
  input  logic                rst,
  input  logic                ras_push,
  input  logic                ras_pop,
  input  fe_fetch_pkg::addr_t push_addr,
  output fe_fetch_pkg::addr_t ras_top
);
  import fe_fetch_pkg::*;

  localparam int PTR_W = `FE_RAS_DEPTH_W;
  localparam int DEPTH = 1 << PTR_W;

  addr_t            stack [DEPTH];
  logic [PTR_W-1:0] ptr;  // points at the top entry

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        stack[i] <= '0;
      end
    end else if (ras_push) begin
      // overflow just overwrites the oldest entry
      stack[ptr + 1'b1] <= push_addr;
      ptr <= ptr + 1'b1;
    end else if (ras_pop) begin
      ptr <= ptr - 1'b1;
    end
  end

  assign ras_top = stack[ptr];

  // a block wins with one branch kind only
  a_push_pop_excl: assert property (
    @(posedge clk) disable iff (rst)
    !(ras_push && ras_pop)
  );

endmodule

`default_nettype wire

//--- fe_next_ip.sv
// next fetch address selection
// slot choice, target mux, history update, redirect priority
// holds the fetch pointer and history registers
`default_nettype none

`include "fe_cfg.svh"

module fe_next_ip (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [1:0]                   slot_hit,
  input  fe_btb_pkg::btb_entry_t [1:0] slot_entry,
  input  logic [1:0]                   dir_taken,
  input  fe_fetch_pkg::addr_t          ras_top,
  input  logic                         irq_load,
  input  fe_fetch_pkg::addr_t          irq_ip,
  input  logic                         ret_valid,
  input  logic                         ret_mispred,
  input  logic                         ret_taken,
  input  fe_fetch_pkg::addr_t          ret_target,
  input  fe_fetch_pkg::addr_t          ret_src_ip,
  input  fe_fetch_pkg::ght_t           ret_ght,
  output fe_fetch_pkg::addr_t          fetch_ip,
  output fe_fetch_pkg::ght_t           fetch_ght,
  output logic                         pred_taken,
  output fe_fetch_pkg::slot_t          pred_slot,
  output logic                         ras_push,
  output logic                         ras_pop,
  output fe_fetch_pkg::addr_t          push_addr
);
  import fe_fetch_pkg::*;
  import fe_btb_pkg::*;

  localparam addr_t BLOCK_BYTES = addr_t'(1 << `FE_BLOCK_BITS);

  logic [1:0] slot_take;
  logic [1:0] slot_cond;
  logic       any_take;
  logic       mispred;
  logic       override;
  slot_t      win_slot;
  btb_entry_t win;
  addr_t      pred_target;
  addr_t      next_ip;
  ght_t       next_ght;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      slot_cond[s] = slot_hit[s] && slot_entry[s].kind == br_cond;
      slot_take[s] = slot_hit[s] && (slot_entry[s].kind != br_cond || dir_taken[s]);
    end
  end

  assign any_take    = |slot_take;
  assign win_slot    = slot_t'(!slot_take[0] && slot_take[1]);  // slot 0 first
  assign win         = slot_entry[win_slot];
  assign pred_target = (win.kind == br_ret) ? ras_top : win.target;
  assign mispred     = ret_valid && ret_mispred;
  assign override    = irq_load || mispred;
  assign push_addr   = fetch_ip + BLOCK_BYTES;

  // squashed block predicts nothing
  assign pred_taken = any_take && !override;
  assign pred_slot  = win_slot;
  assign ras_push   = pred_taken && win.kind == br_call;
  assign ras_pop    = pred_taken && win.kind == br_ret;

  always_comb begin
    if (irq_load) begin
      next_ip  = irq_ip;
      next_ght = fetch_ght;
    end else if (mispred) begin
      next_ip  = ret_taken ? ret_target : ret_src_ip + BLOCK_BYTES;
      next_ght = ret_ght;  // back to the history the branch saw
    end else if (any_take) begin
      next_ip  = pred_target;
      next_ght = (win.kind == br_cond) ? {fetch_ght[`FE_GHT_W-2:0], 1'b1} : fetch_ght;
    end else begin
      next_ip  = push_addr;
      next_ght = (|slot_cond) ? {fetch_ght[`FE_GHT_W-2:0], 1'b0} : fetch_ght;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip  <= `FE_RESET_IP;
      fetch_ght <= '0;
    end else begin
      fetch_ip  <= next_ip;
      fetch_ght <= next_ght;
    end
  end

  // predicted and fall-through pointers stay block aligned
  a_fetch_aligned: assert property (
    @(posedge clk) disable iff (rst)
    !override |=> fetch_ip[`FE_BLOCK_BITS-1:0] == '0
  );

endmodule

`default_nettype wire

//--- fe_frontend.sv
// instruction fetch front end top
// direction predictor, BTB, return stack and next-address logic
`default_nettype none

module fe_frontend (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 irq_load,
  input  fe_fetch_pkg::addr_t  irq_ip,
  input  logic                 ret_valid,
  input  fe_fetch_pkg::slot_t  ret_slot,
  input  fe_btb_pkg::br_kind_t ret_kind,
  input  fe_fetch_pkg::addr_t  ret_target,
  input  logic                 ret_taken,
  input  logic                 ret_mispred,
  input  fe_fetch_pkg::addr_t  ret_src_ip,
  input  fe_fetch_pkg::ght_t   ret_ght,
  output fe_fetch_pkg::addr_t  fetch_ip,
  output fe_fetch_pkg::ght_t   fetch_ght,
  output logic                 pred_taken,
  output fe_fetch_pkg::slot_t  pred_slot
);
  import fe_fetch_pkg::*;
  import fe_btb_pkg::*;

  logic            [1:0] slot_hit;
  btb_entry_t      [1:0] slot_entry;
  logic            [1:0] dir_taken;
  logic                  ras_push;
  logic                  ras_pop;
  addr_t                 push_addr;
  addr_t                 ras_top;

  fe_direction u_direction (
    .clk         (clk),
    .rst         (rst),
    .fetch_ip    (fetch_ip),
    .ght         (fetch_ght),
    .dir_taken   (dir_taken),
    .ret_valid   (ret_valid),
    .ret_mispred (ret_mispred),
    .ret_kind    (ret_kind),
    .ret_slot    (ret_slot),
    .ret_src_ip  (ret_src_ip),
    .ret_ght     (ret_ght)
  );

  fe_btb u_btb (
    .clk        (clk),
    .rst        (rst),
    .fetch_ip   (fetch_ip),
    .slot_hit   (slot_hit),
    .slot_entry (slot_entry),
    .ret_valid  (ret_valid),
    .ret_slot   (ret_slot),
    .ret_src_ip (ret_src_ip),
    .ret_kind   (ret_kind),
    .ret_target (ret_target)
  );

  fe_ras u_ras (
    .clk       (clk),
    .rst       (rst),
    .ras_push  (ras_push),
    .ras_pop   (ras_pop),
    .push_addr (push_addr),
    .ras_top   (ras_top)
  );

  fe_next_ip u_next_ip (
    .clk         (clk),
    .rst         (rst),
    .slot_hit    (slot_hit),
    .slot_entry  (slot_entry),
    .dir_taken   (dir_taken),
    .ras_top     (ras_top),
    .irq_load    (irq_load),
    .irq_ip      (irq_ip),
    .ret_valid   (ret_valid),
    .ret_mispred (ret_mispred),
    .ret_taken   (ret_taken),
    .ret_target  (ret_target),
    .ret_src_ip  (ret_src_ip),
    .ret_ght     (ret_ght),
    .fetch_ip    (fetch_ip),
    .fetch_ght   (fetch_ght),
    .pred_taken  (pred_taken),
    .pred_slot   (pred_slot),
    .ras_push    (ras_push),
    .ras_pop     (ras_pop),
    .push_addr   (push_addr)
  );

endmodule

`default_nettype wire

//--- tb_fe_model.svh
// cycle model of the fetch front end for the testbench
// pointer, history, direction tables, BTB slots and return stack
// reads the testbench's DUT input signals of the current cycle
`ifndef TB_FE_MODEL_SVH
`define TB_FE_MODEL_SVH

addr_t       m_ip;
ght_t        m_ght;
logic [1:0]  m_dir [3][256];     // one toggle bit per slot
logic        m_valid [2][64];
addr_t       m_blk [2][64];      // block address of the installed branch
addr_t       m_target [2][64];
logic [1:0]  m_kind [2][64];
addr_t       m_ras [16];
logic [3:0]  m_sp;
int          m_cond_mis;         // conditional mispredicts so far
logic [1:0]  m_take;
logic [1:0]  m_cond;

// block-number bits joined with the newest history bits
function automatic logic [7:0] m_index(input int t, input addr_t ip, input ght_t h);
  case (t)
    0: return {ip[10:5], h[1:0]};
    1: return {ip[8:5], h[3:0]};
    default: return {ip[6:5], h[5:0]};
  endcase
endfunction

function automatic void model_reset();
  m_ip = `FE_RESET_IP;
  m_ght = '0;
  m_sp = '0;
  m_cond_mis = 0;
  for (int i = 0; i < 256; i++) begin
    for (int t = 0; t < 3; t++) m_dir[t][i] = '0;
  end
  for (int i = 0; i < 64; i++) begin
    for (int s = 0; s < 2; s++) m_valid[s][i] = 1'b0;
  end
  for (int i = 0; i < 16; i++) m_ras[i] = '0;
endfunction

// hits and taken slots of the current block
function automatic void model_lookup();
  logic [5:0] set;
  logic       hit;
  logic       dir;
  set = m_ip[10:5];
  for (int s = 0; s < 2; s++) begin
    hit = m_valid[s][set] && m_blk[s][set][31:5] == m_ip[31:5];
    dir = 1'b0;
    for (int t = 0; t < 3; t++) dir = dir ^ m_dir[t][m_index(t, m_ip, m_ght)][s];
    m_cond[s] = hit && m_kind[s][set] == br_cond;
    m_take[s] = hit && (m_kind[s][set] != br_cond || dir);
  end
endfunction

// state after the coming clock edge, call after model_lookup
function automatic void model_step();
  logic       s;
  logic [5:0] set;
  logic [5:0] rset;
  logic [7:0] idx;
  addr_t      nip;
  ght_t       ng;
  s = !m_take[0];
  set = m_ip[10:5];
  rset = ret_src_ip[10:5];
  nip = m_ip + 32'd32;
  ng = m_ght;
  if (irq_load) begin
    nip = irq_ip;
  end else if (ret_valid && ret_mispred) begin
    nip = ret_taken ? ret_target : ret_src_ip + 32'd32;
    ng = ret_ght;
  end else if (|m_take) begin
    nip = (m_kind[s][set] == br_ret) ? m_ras[m_sp] : m_target[s][set];
    if (m_kind[s][set] == br_call) begin
      m_sp = m_sp + 1'b1;
      m_ras[m_sp] = m_ip + 32'd32;
    end else if (m_kind[s][set] == br_ret) begin
      m_sp = m_sp - 1'b1;
    end
    if (m_kind[s][set] == br_cond) ng = {m_ght[6:0], 1'b1};
  end else if (|m_cond) begin
    ng = {m_ght[6:0], 1'b0};
  end
  if (ret_valid) begin
    m_valid[ret_slot][rset] = 1'b1;
    m_blk[ret_slot][rset] = ret_src_ip;
    m_target[ret_slot][rset] = ret_target;
    m_kind[ret_slot][rset] = ret_kind;
    if (ret_mispred && ret_kind == br_cond) begin
      m_cond_mis++;
      for (int t = 0; t < 3; t++) begin
        if (t == 0 || (t == 1 && m_cond_mis % `FE_THROTTLE_B == 0) ||
            (t == 2 && m_cond_mis % `FE_THROTTLE_C == 0)) begin
          idx = m_index(t, ret_src_ip, ret_ght);
          m_dir[t][idx][ret_slot] = ~m_dir[t][idx][ret_slot];
        end
      end
    end
  end
  m_ip = nip;
  m_ght = ng;
endfunction

`endif

//--- tb_fe_frontend.sv
// testbench for the fetch front end
// directed tests for jumps, conditionals, calls, redirects
// and random traffic, all checked against a cycle model
`default_nettype none

`include "fe_cfg.svh"

module tb_fe_frontend;
  import fe_fetch_pkg::*;
  import fe_btb_pkg::*;

  // cycles per test, reset to random traffic
  localparam int TIMEOUT = 21 + 72 + 35 + 10 + 40 + 2 + 2000 + 100;

  logic     clk = 1'b0;
  logic     rst;
  logic     irq_load;
  addr_t    irq_ip;
  logic     ret_valid;
  slot_t    ret_slot;
  br_kind_t ret_kind;
  addr_t    ret_target;
  logic     ret_taken;
  logic     ret_mispred;
  addr_t    ret_src_ip;
  ght_t     ret_ght;
  addr_t    fetch_ip;
  ght_t     fetch_ght;
  logic     pred_taken;
  slot_t    pred_slot;

  int       seed;
  int       cycle_cnt = 0;
  int       errors = 0;
  int       test_errors = 0;
  int       tests_ok = 0;
  int       tests_bad = 0;
  addr_t    obs_ip;     // outputs sampled in the last cycle
  ght_t     obs_ght;
  logic     obs_taken;
  slot_t    obs_slot;

  `include "tb_fe_model.svh"

  fe_frontend dut (
    .clk         (clk),
    .rst         (rst),
    .irq_load    (irq_load),
    .irq_ip      (irq_ip),
    .ret_valid   (ret_valid),
    .ret_slot    (ret_slot),
    .ret_kind    (ret_kind),
    .ret_target  (ret_target),
    .ret_taken   (ret_taken),
    .ret_mispred (ret_mispred),
    .ret_src_ip  (ret_src_ip),
    .ret_ght     (ret_ght),
    .fetch_ip    (fetch_ip),
    .fetch_ght   (fetch_ght),
    .pred_taken  (pred_taken),
    .pred_slot   (pred_slot)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
    errors++;
    test_errors++;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, test_errors);
      tests_bad++;
    end
    test_errors = 0;
  endtask

  function automatic addr_t rand_block();
    addr_t a;
    a = $random(seed);
    a[4:0] = '0;
    return a;
  endfunction

  // 128 blocks, two tags per BTB set
  function automatic addr_t pool_block();
    logic [31:0] r;
    r = $random(seed);
    return 32'h0004_0000 | {20'b0, r[6:0], 5'b0};
  endfunction

  // compare with the model mid-cycle, then move to the next cycle
  task automatic tick();
    logic exp_taken;
    @(negedge clk);
    model_lookup();
    exp_taken = (|m_take) && !(irq_load || (ret_valid && ret_mispred));
    obs_ip = fetch_ip;
    obs_ght = fetch_ght;
    obs_taken = pred_taken;
    obs_slot = pred_slot;
    if (fetch_ip !== m_ip) report_mismatch("fetch_ip", fetch_ip, m_ip);
    if (fetch_ght !== m_ght) report_mismatch("fetch_ght", fetch_ght, m_ght);
    if (pred_taken !== exp_taken) report_mismatch("pred_taken", pred_taken, exp_taken);
    if (exp_taken && pred_slot !== !m_take[0]) begin
      report_mismatch("pred_slot", pred_slot, !m_take[0]);
    end
    model_step();
    @(posedge clk);
    #1;
    irq_load = 1'b0;
    ret_valid = 1'b0;
    ret_mispred = 1'b0;
    ret_taken = 1'b0;
  endtask

  task automatic retire_tick(input addr_t src, input slot_t slot, input br_kind_t kind,
                             input addr_t target, input logic taken, input logic mispred,
                             input ght_t ght);
    ret_valid = 1'b1;
    ret_src_ip = src;
    ret_slot = slot;
    ret_kind = kind;
    ret_target = target;
    ret_taken = taken;
    ret_mispred = mispred;
    ret_ght = ght;
    tick();
  endtask

  task automatic irq_tick(input addr_t ip);
    irq_load = 1'b1;
    irq_ip = ip;
    tick();
  endtask

  task automatic test_reset();
    addr_t prev;
    tick();
    if (obs_ip !== `FE_RESET_IP) report_mismatch("fetch_ip after reset", obs_ip, `FE_RESET_IP);
    if (obs_ght !== '0) report_mismatch("fetch_ght after reset", obs_ght, '0);
    if (obs_taken !== 1'b0) report_mismatch("pred_taken after reset", obs_taken, 1'b0);
    for (int i = 0; i < 20; i++) begin
      prev = obs_ip;
      tick();
      if (obs_ip !== prev + 32'd32) report_mismatch("fall-through", obs_ip, prev + 32'd32);
    end
    end_test("reset and fall-through");
  endtask

  task automatic test_jump();
    addr_t blk;
    addr_t tgt0;
    addr_t tgt1;
    slot_t s;
    for (int i = 0; i < 8; i++) begin
      blk = rand_block();
      tgt0 = rand_block();
      s = slot_t'($random(seed));
      retire_tick(blk, s, br_jump, tgt0, 1'b1, 1'b0, '0);
      irq_tick(blk);
      tick();
      if (obs_taken !== 1'b1) report_mismatch("pred_taken on jump", obs_taken, 1'b1);
      if (obs_slot !== s) report_mismatch("pred_slot on jump", obs_slot, s);
      tick();
      if (obs_ip !== tgt0) report_mismatch("jump target", obs_ip, tgt0);
      // jumps in both slots
      blk = rand_block();
      tgt0 = rand_block();
      tgt1 = rand_block();
      retire_tick(blk, 1'b1, br_jump, tgt1, 1'b1, 1'b0, '0);
      retire_tick(blk, 1'b0, br_jump, tgt0, 1'b1, 1'b0, '0);
      irq_tick(blk);
      tick();
      if (obs_slot !== 1'b0) report_mismatch("pred_slot with two jumps", obs_slot, 1'b0);
      tick();
      if (obs_ip !== tgt0) report_mismatch("slot 0 target", obs_ip, tgt0);
    end
    end_test("jump prediction");
  endtask

  task automatic test_cond();
    addr_t blk;
    slot_t s;
    ght_t  g;
    int    flips;
    blk = rand_block();
    s = slot_t'($random(seed));
    retire_tick(blk, s, br_cond, blk, 1'b0, 1'b0, '0);
    irq_tick(blk);
    tick();
    g = obs_ght;
    if (obs_taken !== 1'b0) report_mismatch("pred_taken on new cond", obs_taken, 1'b0);
    for (int k = 1; k <= 16; k++) begin
      retire_tick(blk, s, br_cond, blk, 1'b1, 1'b1, g);
      if (k == 1 && obs_ip !== blk + 32'd32) begin
        report_mismatch("cond fall-through", obs_ip, blk + 32'd32);
      end
      if (k == 1 && obs_ght !== {g[6:0], 1'b0}) begin
        report_mismatch("not-taken shift", obs_ght, {g[6:0], 1'b0});
      end
      tick();
      // table A every time, B every 4th, C every 16th
      flips = k + k / `FE_THROTTLE_B + k / `FE_THROTTLE_C;
      if (obs_ip !== blk) report_mismatch("cond redirect", obs_ip, blk);
      if (obs_ght !== g) report_mismatch("restored history", obs_ght, g);
      if (obs_taken !== flips[0]) report_mismatch("toggled direction", obs_taken, flips[0]);
    end
    end_test("conditional toggles");
  endtask

  task automatic test_call_return();
    addr_t p1;
    addr_t p2;
    addr_t r;
    p1 = rand_block();
    // chain blocks sit in distinct BTB sets
    p2 = p1 + 32'h0001_0040;
    r = p1 + 32'h0002_0080;
    retire_tick(p1, 1'b0, br_call, p2, 1'b1, 1'b0, '0);
    retire_tick(p2, 1'b0, br_call, r, 1'b1, 1'b0, '0);
    retire_tick(r, 1'b0, br_ret, '0, 1'b1, 1'b0, '0);
    retire_tick(p2 + 32'd32, 1'b0, br_ret, '0, 1'b1, 1'b0, '0);
    irq_tick(p1);
    tick();
    if (obs_ip !== p1) report_mismatch("outer call block", obs_ip, p1);
    tick();
    if (obs_ip !== p2) report_mismatch("inner call block", obs_ip, p2);
    tick();
    if (obs_ip !== r) report_mismatch("callee", obs_ip, r);
    tick();
    if (obs_ip !== p2 + 32'd32) report_mismatch("inner return", obs_ip, p2 + 32'd32);
    tick();
    if (obs_ip !== p1 + 32'd32) report_mismatch("outer return", obs_ip, p1 + 32'd32);
    end_test("call and return");
  endtask

  task automatic test_mispredict();
    addr_t    src;
    addr_t    tgt;
    addr_t    exp_ip;
    ght_t     g;
    logic     taken;
    br_kind_t kind;
    for (int i = 0; i < 20; i++) begin
      src = rand_block();
      tgt = rand_block();
      g = ght_t'($random(seed));
      taken = 1'($random(seed));
      kind = br_kind_t'(2'($random(seed)));
      exp_ip = taken ? tgt : src + 32'd32;
      retire_tick(src, slot_t'($random(seed)), kind, tgt, taken, 1'b1, g);
      tick();
      if (obs_ip !== exp_ip) report_mismatch("mispredict redirect", obs_ip, exp_ip);
      if (obs_ght !== g) report_mismatch("mispredict history", obs_ght, g);
    end
    end_test("mispredict redirect");
  endtask

  task automatic test_irq_priority();
    addr_t ip;
    ip = rand_block();
    irq_load = 1'b1;
    irq_ip = ip;
    retire_tick(rand_block(), 1'b0, br_jump, rand_block(), 1'b1, 1'b1, 8'h5a);
    tick();
    if (obs_ip !== ip) report_mismatch("irq over mispredict", obs_ip, ip);
    end_test("irq priority");
  endtask

  task automatic test_random_traffic();
    logic [31:0] r;
    for (int i = 0; i < 2000; i++) begin
      r = $random(seed);
      irq_load = (r[11:7] == 5'd0);   // about 1 in 32
      irq_ip = pool_block();
      ret_valid = (r[1:0] == 2'd0);
      ret_mispred = r[2];
      ret_taken = r[3];
      ret_slot = r[4];
      ret_kind = br_kind_t'(r[6:5]);
      ret_src_ip = pool_block();
      ret_target = pool_block();
      ret_ght = ght_t'($random(seed));
      tick();
    end
    end_test("random traffic");
  endtask

  initial begin
    seed = 32'h8d2f;
    rst = 1'b1;
    irq_load = 1'b0;
    irq_ip = '0;
    ret_valid = 1'b0;
    ret_slot = 1'b0;
    ret_kind = br_cond;
    ret_target = '0;
    ret_taken = 1'b0;
    ret_mispred = 1'b0;
    ret_src_ip = '0;
    ret_ght = '0;
    model_reset();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_jump();
    test_cond();
    test_call_return();
    test_mispredict();
    test_irq_priority();
    test_random_traffic();
    $display("%0d tests passed, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
fe_fetch_pkg.sv
fe_btb_pkg.sv
fe_table.sv
fe_direction.sv
fe_btb.sv
fe_ras.sv
fe_next_ip.sv
fe_frontend.sv
tb_fe_frontend.sv

//--- Bender.yml
package:
  name: fe_frontend

sources:
  - include_dirs:
      - .
    files:
      - fe_fetch_pkg.sv
      - fe_btb_pkg.sv
      - fe_table.sv
      - fe_direction.sv
      - fe_btb.sv
      - fe_ras.sv
      - fe_next_ip.sv
      - fe_frontend.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fe_frontend.sv
